// File: Makefile
# Verilator build of the vector load engine testbench

VERILATOR ?= verilator
TOP       ?= vld_tb
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
FILELIST  ?= list.f

SRCS := $(wildcard design/*.sv) test/vld_tb.sv test/vld_tb_tasks.svh
BIN  := $(BUILD_DIR)/$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)

# Exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

// File: design/vld_addr_gen.sv
// ==========================================================================
// Element address generation for unit-strided and strided loads
// ==========================================================================
`timescale 1ns/1ps

module vld_addr_gen (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        instr_start_i,  // Load base and stride
    input  logic [vld_pkg::ADDR_W-1:0]  base_i,
    input  logic [vld_pkg::ADDR_W-1:0]  stride_i,
    input  vld_pkg::mem_op_e            op_i,
    input  logic                        req_take_i,     // Current element granted
    output logic [vld_pkg::ADDR_W-1:0]  addr_o
);

    logic [vld_pkg::ADDR_W-1:0] addr_q;    // Address of the next element to issue
    logic [vld_pkg::ADDR_W-1:0] stride_q;
    logic [vld_pkg::ADDR_W-1:0] step;

    // Byte step per element
    always_comb begin
        case (op_i)
            vld_pkg::OP_UNIT_STRIDED: step = vld_pkg::UNIT_STEP;
            vld_pkg::OP_STRIDED:      step = stride_q;
            default:                  step = vld_pkg::UNIT_STEP;
        endcase
    end

    // Address keeps running across rows, expansion stays in element order
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            addr_q <= '0;
        end else if (instr_start_i) begin
            addr_q <= base_i;
        end else if (req_take_i) begin
            addr_q <= addr_q + step;  // Held while grant is low
        end
    end

    always_ff @(posedge clk_i) begin
        if (instr_start_i) begin
            stride_q <= stride_i;
        end
    end

    assign addr_o = addr_q;

endmodule

// File: design/vld_elem_sched.sv
// ==========================================================================
// Lane scoreboard and lane pointer, one memory request per element
// ==========================================================================
`timescale 1ns/1ps

module vld_elem_sched (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        instr_start_i,
    input  logic                        row_start_i,
    input  vld_pkg::lane_mask_t         row_mask_i,     // Lanes of the starting row
    input  logic                        row_done_i,
    input  logic                        grant_i,
    output logic                        req_en_o,
    output logic [vld_pkg::LANE_W-1:0]  ticket_o,
    output logic                        req_take_o,     // Request granted this cycle
    output vld_pkg::lane_mask_t         active_mask_o,
    output logic                        row_idle_o
);

    vld_pkg::lane_mask_t          pending_q;  // Lanes still to be requested
    vld_pkg::lane_mask_t          active_q;   // Lanes of the row not yet written back
    logic [vld_pkg::LANE_W-1:0]   ptr_q;      // Lane being requested
    logic                         load_row;

    assign load_row = instr_start_i | row_start_i;

    // ======================================================================
    // Request side
    // ======================================================================
    assign req_en_o   = pending_q[ptr_q];
    assign ticket_o   = ptr_q;              // Lane number is the ticket
    assign req_take_o = req_en_o & grant_i;

    // Lane pointer, walks the row from lane 0
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ptr_q <= '0;
        end else if (load_row) begin
            ptr_q <= '0;
        end else if (req_take_o) begin
            ptr_q <= ptr_q + 1'b1;  // Past the last lane points at a clear bit
        end
    end

    // Pending lanes
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pending_q <= '0;
        end else if (load_row) begin
            pending_q <= row_mask_i;
        end else if (req_take_o) begin
            pending_q[ptr_q] <= 1'b0;  // Issued, waiting on its response
        end
    end

    // ======================================================================
    // Active lanes, held until the row is written back
    // ======================================================================
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            active_q <= '0;
        end else if (load_row) begin
            active_q <= row_mask_i;
        end else if (row_done_i) begin
            active_q <= '0;
        end
    end

    assign active_mask_o = active_q;
    assign row_idle_o    = ~|pending_q & ~|active_q;  // Nothing issued or outstanding

    // A stalled request keeps its lane and stays up until granted
    a_req_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (req_en_o && !grant_i) |=> (req_en_o && $stable(ticket_o)))
        else $error("memory request dropped or changed before grant");

endmodule

// File: design/vld_instr_seq.sv
// ==========================================================================
// Instruction acceptance and row sequencing of an expanded vector load
// ==========================================================================
`timescale 1ns/1ps

module vld_instr_seq (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        valid_i,
    input  vld_pkg::vld_instr_t         instr_i,
    output logic                        ready_o,
    input  logic                        row_idle_i,     // Scheduler has nothing in flight
    input  logic                        row_done_i,     // Current row written back
    output logic                        instr_start_o,  // Accept pulse
    output logic                        row_start_o,    // Next row of the expansion
    output vld_pkg::lane_mask_t         row_mask_o,     // Lanes of the coming row
    output logic [vld_pkg::VREG_W-1:0]  row_dst_o,
    output logic [vld_pkg::ADDR_W-1:0]  base_o,
    output logic [vld_pkg::ADDR_W-1:0]  stride_o,
    output vld_pkg::mem_op_e            op_o
);

    localparam logic [vld_pkg::VL_W-1:0] LANES_VL = vld_pkg::NUM_LANES[vld_pkg::VL_W-1:0];

    logic                        accept;
    logic                        busy_q;       // From acceptance to the last row_done
    logic [vld_pkg::VL_W-1:0]    remain_q;     // Elements not yet written back
    logic [vld_pkg::VREG_W-1:0]  row_cnt_q;    // Rows already finished
    logic [vld_pkg::VREG_W-1:0]  dst_q;
    vld_pkg::mem_op_e            op_q;
    logic                        row_start_q;
    logic                        more_rows;    // Another row follows the current one
    logic [vld_pkg::VL_W-1:0]    row_elems;
    logic [vld_pkg::VL_W-1:0]    mask_cnt;

    // Prefix mask of the first cnt lanes, saturating at a full row
    function automatic vld_pkg::lane_mask_t lane_mask(input logic [vld_pkg::VL_W-1:0] cnt);
        vld_pkg::lane_mask_t m;
        for (int i = 0; i < vld_pkg::NUM_LANES; i++) begin
            m[i] = (cnt > i[vld_pkg::VL_W-1:0]);
        end
        return m;
    endfunction

    assign ready_o       = ~busy_q & row_idle_i;
    assign accept        = valid_i & ready_o;
    assign instr_start_o = accept;
    assign row_start_o   = row_start_q;

    assign more_rows = (remain_q > LANES_VL);
    assign row_elems = more_rows ? LANES_VL : remain_q;  // Size of the row in flight

    // First row straight from the input, later rows from the count left over
    assign mask_cnt   = accept ? instr_i.vl : remain_q;
    assign row_mask_o = lane_mask(mask_cnt);
    assign row_dst_o  = accept ? instr_i.dst : dst_q + row_cnt_q;

    // Base and stride handed over in the accept cycle
    assign base_o   = instr_i.base;
    assign stride_o = instr_i.stride;
    assign op_o     = op_q;

    // ======================================================================
    // Row sequencing
    // ======================================================================
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            busy_q      <= 1'b0;
            remain_q    <= '0;
            row_cnt_q   <= '0;
            row_start_q <= 1'b0;
        end else begin
            row_start_q <= row_done_i & more_rows;  // One cycle after the writeback
            if (accept) begin
                busy_q    <= 1'b1;
                remain_q  <= instr_i.vl;
                row_cnt_q <= '0;
            end else if (row_done_i) begin
                remain_q <= remain_q - row_elems;
                if (more_rows) begin
                    row_cnt_q <= row_cnt_q + 1'b1;  // Next destination register
                end else begin
                    busy_q <= 1'b0;                 // Last row, ready rises next cycle
                end
            end
        end
    end

    // Fields used for the whole instruction
    always_ff @(posedge clk_i) begin
        if (accept) begin
            dst_q <= instr_i.dst;
            op_q  <= instr_i.op;
        end
    end

    // Issuers never present an empty vector
    a_vl_nonzero: assert property (@(posedge clk_i) disable iff (!rstn_i)
        valid_i |-> (instr_i.vl != '0))
        else $error("vector load presented with vl of zero");

endmodule

// File: design/vld_pkg.sv
// ==========================================================================
// Shared constants, addressing-mode enum and packed structs of the vector
// load engine
// ==========================================================================
package vld_pkg;

    // ======================================================================
    // Geometry
    // ======================================================================
    localparam int NUM_LANES = 8;   // Elements per vector register
    localparam int NUM_VREGS = 32;  // Architectural vector registers
    localparam int DATA_W    = 32;  // Element width
    localparam int ADDR_W    = 32;  // Byte address width

    localparam int LANE_W = $clog2(NUM_LANES);              // Lane index
    localparam int VREG_W = $clog2(NUM_VREGS);              // Register index
    localparam int VL_W   = $clog2(NUM_LANES * NUM_VREGS) + 1;  // Up to full group

    // Byte step between consecutive unit-strided elements
    localparam logic [ADDR_W-1:0] UNIT_STEP = 32'd4;

    // ======================================================================
    // Types
    // ======================================================================
    typedef enum logic [1:0] {
        OP_UNIT_STRIDED = 2'd0,  // Address steps by UNIT_STEP
        OP_STRIDED      = 2'd1   // Address steps by the stride
    } mem_op_e;

    typedef logic [NUM_LANES-1:0] lane_mask_t;  // One bit per lane

    // Load instruction as seen at the input
    typedef struct packed {
        logic [ADDR_W-1:0] base;    // First element address
        logic [ADDR_W-1:0] stride;  // Byte distance, strided mode only
        logic [VL_W-1:0]   vl;      // Element count, never zero
        logic [VREG_W-1:0] dst;     // First destination register
        mem_op_e           op;
    } vld_instr_t;

    // One element request towards memory
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LANE_W-1:0] ticket;  // Lane that owns the element
    } mem_req_t;

    // Response, may come back out of order
    typedef struct packed {
        logic [LANE_W-1:0] ticket;
        logic [DATA_W-1:0] data;
    } mem_resp_t;

    // Register file writeback of one row
    typedef struct packed {
        lane_mask_t                         en;    // Per-lane write enable
        logic [VREG_W-1:0]                  dst;
        logic [NUM_LANES-1:0][DATA_W-1:0]   data;  // Lane 0 in the low word
    } wb_t;

endpackage

// File: design/vld_row_buffer.sv
// ==========================================================================
// Per-lane response collection, row writeback and register unlock
// ==========================================================================
`timescale 1ns/1ps

module vld_row_buffer (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        instr_start_i,
    input  logic                        row_start_i,
    input  logic [vld_pkg::VREG_W-1:0]  row_dst_i,
    input  vld_pkg::lane_mask_t         active_mask_i,
    input  logic                        resp_valid_i,
    input  vld_pkg::mem_resp_t          resp_i,
    output vld_pkg::wb_t                wb_o,
    output logic                        row_done_o,
    output logic                        unlock_en_o,
    output logic [vld_pkg::VREG_W-1:0]  unlock_reg_o
);

    logic [vld_pkg::NUM_LANES-1:0][vld_pkg::DATA_W-1:0] scratch_q;  // Lane data
    vld_pkg::lane_mask_t                                served_q;   // Lanes answered
    logic [vld_pkg::VREG_W-1:0]                         dst_q;      // Register of this row
    logic                                               row_load;
    logic                                               row_done;

    assign row_load = instr_start_i | row_start_i;

    // Response data lands in its own lane, any order
    always_ff @(posedge clk_i) begin
        if (resp_valid_i) begin
            scratch_q[resp_i.ticket] <= resp_i.data;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            served_q <= '0;
            dst_q    <= '0;
        end else if (row_load) begin
            served_q <= '0;         // Fresh row
            dst_q    <= row_dst_i;
        end else if (resp_valid_i) begin
            served_q[resp_i.ticket] <= 1'b1;
        end
    end

    // ======================================================================
    // Writeback once every active lane is served
    // ======================================================================
    // Active mask clears on row_done, so this lasts one cycle
    assign row_done = (served_q == active_mask_i) & |active_mask_i;

    always_comb begin
        wb_o.en   = row_done ? served_q : '0;
        wb_o.dst  = dst_q;
        wb_o.data = scratch_q;
    end

    assign row_done_o   = row_done;
    assign unlock_en_o  = row_done;  // Unlock together with the writeback
    assign unlock_reg_o = dst_q;

    // Responses only come back for lanes issued in the current row
    a_resp_active: assert property (@(posedge clk_i) disable iff (!rstn_i)
        resp_valid_i |-> active_mask_i[resp_i.ticket])
        else $error("response ticket %0d outside the active row", resp_i.ticket);

endmodule

// File: design/vld_top.sv
// ==========================================================================
// Vector load engine top level, sequencer, address generator, scheduler
// and row buffer
// ==========================================================================
`timescale 1ns/1ps

module vld_top (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    // Instruction in
    input  logic                        valid_i,
    input  vld_pkg::vld_instr_t         instr_i,
    output logic                        ready_o,
    // Memory requests
    input  logic                        grant_i,
    output logic                        req_en_o,
    output vld_pkg::mem_req_t           req_o,
    // Memory responses, no back-pressure
    input  logic                        resp_valid_i,
    input  vld_pkg::mem_resp_t          resp_i,
    // Register file writeback and unlock
    output vld_pkg::wb_t                wb_o,
    output logic                        unlock_en_o,
    output logic [vld_pkg::VREG_W-1:0]  unlock_reg_o
);

    logic                        instr_start;
    logic                        row_start;
    vld_pkg::lane_mask_t         row_mask;
    logic [vld_pkg::VREG_W-1:0]  row_dst;
    logic [vld_pkg::ADDR_W-1:0]  base;
    logic [vld_pkg::ADDR_W-1:0]  stride;
    vld_pkg::mem_op_e            op;
    logic                        req_take;
    logic [vld_pkg::LANE_W-1:0]  ticket;
    logic [vld_pkg::ADDR_W-1:0]  addr;
    vld_pkg::lane_mask_t         active_mask;
    logic                        row_idle;
    logic                        row_done;

    vld_instr_seq u_instr_seq (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .valid_i       (valid_i),
        .instr_i       (instr_i),
        .ready_o       (ready_o),
        .row_idle_i    (row_idle),
        .row_done_i    (row_done),
        .instr_start_o (instr_start),
        .row_start_o   (row_start),
        .row_mask_o    (row_mask),
        .row_dst_o     (row_dst),
        .base_o        (base),
        .stride_o      (stride),
        .op_o          (op)
    );

    vld_addr_gen u_addr_gen (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .instr_start_i (instr_start),
        .base_i        (base),
        .stride_i      (stride),
        .op_i          (op),
        .req_take_i    (req_take),
        .addr_o        (addr)
    );

    vld_elem_sched u_elem_sched (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .instr_start_i (instr_start),
        .row_start_i   (row_start),
        .row_mask_i    (row_mask),
        .row_done_i    (row_done),
        .grant_i       (grant_i),
        .req_en_o      (req_en_o),
        .ticket_o      (ticket),
        .req_take_o    (req_take),
        .active_mask_o (active_mask),
        .row_idle_o    (row_idle)
    );

    vld_row_buffer u_row_buffer (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .instr_start_i (instr_start),
        .row_start_i   (row_start),
        .row_dst_i     (row_dst),
        .active_mask_i (active_mask),
        .resp_valid_i  (resp_valid_i),
        .resp_i        (resp_i),
        .wb_o          (wb_o),
        .row_done_o    (row_done),
        .unlock_en_o   (unlock_en_o),
        .unlock_reg_o  (unlock_reg_o)
    );

    // Request struct from the address generator and the lane pointer
    assign req_o.addr   = addr;
    assign req_o.ticket = ticket;

endmodule

// File: list.f
+incdir+test
design/vld_pkg.sv
design/vld_instr_seq.sv
design/vld_addr_gen.sv
design/vld_elem_sched.sv
design/vld_row_buffer.sv
design/vld_top.sv
test/vld_tb.sv

// File: test/vld_tb_tasks.svh
// ==========================================================================
// Random numbers, compare tasks, instruction driver and directed tests
// ==========================================================================

// Memory data and random source
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function logic [31:0] rand_next();
    rng_state = xorshift32(rng_state);
    return rng_state;
endfunction

task report_error(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
endtask

task fail_value(input string msg);
    $display("Fail at %0t: %s", $time, msg);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
endtask

// ==========================================================================
// Compare tasks
// ==========================================================================
task compare_req(input vld_pkg::mem_req_t got, input vld_pkg::mem_req_t exp);
    if (got !== exp) begin
        fail_value($sformatf("request addr %h ticket %0d, expected addr %h ticket %0d",
            got.addr, got.ticket, exp.addr, exp.ticket));
    end
endtask

task compare_wb(input vld_pkg::wb_t got, input vld_pkg::wb_t exp);
    if (got.en !== exp.en || got.dst !== exp.dst) begin
        fail_value($sformatf("writeback en %b dst %0d, expected en %b dst %0d",
            got.en, got.dst, exp.en, exp.dst));
    end
    for (int i = 0; i < vld_pkg::NUM_LANES; i++) begin
        if (exp.en[i] && got.data[i] !== exp.data[i]) begin  // Disabled lanes are stale
            fail_value($sformatf("lane %0d data %h, expected %h", i, got.data[i],
                exp.data[i]));
        end
    end
endtask

task compare_reg(input logic [vld_pkg::VREG_W-1:0] got,
                 input logic [vld_pkg::VREG_W-1:0] exp);
    if (got !== exp) begin
        fail_value($sformatf("unlock register %0d, expected %0d", got, exp));
    end
endtask

task check_request(input vld_pkg::mem_req_t got);
    if (exp_req.size() == 0) report_error("memory request with none expected");
    compare_req(got, exp_req.pop_front());
endtask

task check_writeback(input vld_pkg::wb_t got, input logic [vld_pkg::VREG_W-1:0] unlock);
    vld_pkg::wb_t exp;
    if (exp_wb.size() == 0) report_error("writeback with none expected");
    exp = exp_wb.pop_front();
    compare_wb(got, exp);
    compare_reg(unlock, exp.dst);   // Unlock goes with the row
    wb_left--;
endtask

// ==========================================================================
// Instruction driver, expected traffic from the addressing rules
// ==========================================================================
task issue_load(input logic [31:0] base, input logic [31:0] stride, input int vl,
                input int dst, input vld_pkg::mem_op_e op);
    vld_pkg::mem_req_t r;
    vld_pkg::wb_t      w;
    logic [31:0]       step;
    logic [31:0]       addr;
    int                e;
    valid_i         = 1'b1;
    instr_i.base    = base;
    instr_i.stride  = stride;
    instr_i.vl      = vl[vld_pkg::VL_W-1:0];
    instr_i.dst     = dst[vld_pkg::VREG_W-1:0];
    instr_i.op      = op;
    do @(posedge clk_i); while (!ready_o);   // Accepted at this edge
    #2 valid_i = 1'b0;
    if (exp_wb.size() != 0) report_error("instruction taken before the previous writeback");
    step = (op == vld_pkg::OP_STRIDED) ? stride : 32'd4;
    for (int row = 0; row * vld_pkg::NUM_LANES < vl; row++) begin
        w     = '0;
        w.dst = dst[vld_pkg::VREG_W-1:0] + row[vld_pkg::VREG_W-1:0];
        for (int lane = 0; lane < vld_pkg::NUM_LANES; lane++) begin
            e = row * vld_pkg::NUM_LANES + lane;
            if (e < vl) begin
                addr         = base + step * e;   // Element order across rows
                r.addr       = addr;
                r.ticket     = lane[vld_pkg::LANE_W-1:0];
                exp_req.push_back(r);
                w.en[lane]   = 1'b1;
                w.data[lane] = xorshift32(addr);
            end
        end
        exp_wb.push_back(w);
        wb_left++;
    end
endtask

task wait_done();
    while (exp_wb.size() != 0 || !ready_o) @(posedge clk_i);
    #2;
endtask

// ==========================================================================
// Directed tests
// ==========================================================================
task test_unit_full();
    issue_load(32'h0000_1000, 32'd0, vld_pkg::NUM_LANES, 3, vld_pkg::OP_UNIT_STRIDED);
    wait_done();
endtask

task test_strided_short();
    issue_load(32'h0000_2000, 32'd12, 5, 7, vld_pkg::OP_STRIDED);
    wait_done();
endtask

task test_expand();
    issue_load(32'h0000_3000, 32'd0, 20, 10, vld_pkg::OP_UNIT_STRIDED);  // Rows 8, 8, 4
    wait_done();
endtask

task test_stall_reorder();
    stall_en = 1'b1;
    issue_load(32'h0000_4000, 32'h40, 16, 20, vld_pkg::OP_STRIDED);
    wait_done();
    stall_en = 1'b0;
endtask

task test_back_to_back();
    issue_load(32'h0000_5000, 32'd0, 12, 1, vld_pkg::OP_UNIT_STRIDED);
    issue_load(32'h0000_6000, 32'd8, 3, 30, vld_pkg::OP_STRIDED);  // Waits behind the first
    wait_done();
endtask

// File: test/vld_tb.sv
// ==========================================================================
// Testbench of the vector load engine with clock, reset, memory model,
// timeout and the directed test sequence
// ==========================================================================
`timescale 1ns/1ps

module vld_tb;

    // 5 tests, at most 32 elements, about 20 cycles each, plus margin
    localparam int MAX_CYCLES = 4000;

    logic                        clk_i;
    logic                        rstn_i;
    logic                        valid_i;
    vld_pkg::vld_instr_t         instr_i;
    logic                        ready_o;
    logic                        grant_i;
    logic                        req_en_o;
    vld_pkg::mem_req_t           req_o;
    logic                        resp_valid_i;
    vld_pkg::mem_resp_t          resp_i;
    vld_pkg::wb_t                wb_o;
    logic                        unlock_en_o;
    logic [vld_pkg::VREG_W-1:0]  unlock_reg_o;

    // Scoreboard state, filled at acceptance, drained by the monitor
    vld_pkg::mem_req_t exp_req[$];
    vld_pkg::wb_t      exp_wb[$];
    int                wb_left;       // Writebacks still owed to the engine
    int                cycle_cnt;
    logic [31:0]       rng_state;
    logic              stall_en;      // Random grant drops

    // Memory model, outstanding responses
    logic [vld_pkg::LANE_W-1:0] pend_ticket[$];
    logic [vld_pkg::DATA_W-1:0] pend_data[$];
    int                         pend_wait[$];

    `include "vld_tb_tasks.svh"

    vld_top dut (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .valid_i      (valid_i),
        .instr_i      (instr_i),
        .ready_o      (ready_o),
        .grant_i      (grant_i),
        .req_en_o     (req_en_o),
        .req_o        (req_o),
        .resp_valid_i (resp_valid_i),
        .resp_i       (resp_i),
        .wb_o         (wb_o),
        .unlock_en_o  (unlock_en_o),
        .unlock_reg_o (unlock_reg_o)
    );

    initial clk_i = 1'b0;
    always #20 clk_i = ~clk_i;  // 40 ns period

    // ======================================================================
    // Monitor and memory responder
    // ======================================================================
    always @(posedge clk_i) begin
        int due[$];
        int pick;
        if (rstn_i) begin
            if (req_en_o && grant_i) begin   // Request taken this edge
                check_request(req_o);
                pend_ticket.push_back(req_o.ticket);
                pend_data.push_back(xorshift32(req_o.addr));
                pend_wait.push_back(1 + int'(rand_next() % 4));
            end
            if (unlock_en_o != |wb_o.en) begin
                report_error("unlock and writeback enables disagree");
            end
            if (|wb_o.en) begin
                check_writeback(wb_o, unlock_reg_o);
            end
            if (ready_o && wb_left > 0) begin
                report_error("ready_o high before the last writeback");
            end
        end
        #2;
        grant_i = stall_en ? (rand_next() % 3 != 0) : 1'b1;
        due.delete();                       // Indices of this cycle only
        for (int i = 0; i < pend_wait.size(); i++) begin
            pend_wait[i] = pend_wait[i] - 1;
            if (pend_wait[i] <= 0) due.push_back(i);
        end
        resp_valid_i = 1'b0;
        if (due.size() > 0) begin           // One due response, random choice
            pick = due[rand_next() % due.size()];
            resp_valid_i = 1'b1;
            resp_i.ticket = pend_ticket[pick];
            resp_i.data   = pend_data[pick];
            pend_ticket.delete(pick);
            pend_data.delete(pick);
            pend_wait.delete(pick);
        end
    end

    // Timeout
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout, the engine stopped making progress");
            $display("Regression failed");
            $fatal(1, "cycle limit reached");
        end
    end

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        rstn_i       = 1'b0;
        valid_i      = 1'b0;
        instr_i      = '0;
        grant_i      = 1'b0;
        resp_valid_i = 1'b0;
        resp_i       = '0;
        wb_left      = 0;
        cycle_cnt    = 0;
        stall_en     = 1'b0;
        rng_state    = 32'hb652a141;
        repeat (3) @(posedge clk_i);
        #2 rstn_i = 1'b1;
        @(posedge clk_i);
        if (!ready_o || req_en_o || unlock_en_o || |wb_o.en) begin
            report_error("outputs not idle after reset");
        end
        #2;
        test_unit_full();
        test_strided_short();
        test_expand();
        test_stall_reorder();
        test_back_to_back();
        $display("Regression passed");
        $finish;
    end

endmodule
